//--- fpslice_decode.sv
/* Input side of the slice: lane operands, FP16 box check and lane enables.
   Purely combinational, sits between the request port and the lanes. */
module fpslice_decode #(
  parameter bit EnableVectors = 1'b1
) (
  input  fpslice_pkg::slice_req_t  req_i,
  output fpslice_pkg::fp_word_u    lane_a_o,
  output fpslice_pkg::fp_word_u    lane_b_o,
  output fpslice_pkg::lane_mask_t  lane_en_o,
  output fpslice_pkg::slice_meta_t meta_o
);

  logic vector;
  logic is_fp16;
  logic scalar_fp16;

  // Vector requests degrade to scalar when vectors are disabled
  assign vector      = req_i.vector & EnableVectors;
  assign is_fp16     = (req_i.fmt == fpslice_pkg::FP16);
  assign scalar_fp16 = is_fp16 & ~vector;

  // Lane 0 serves every FP16 item, upper lanes only vector items
  for (genvar lane = 0; lane < int'(fpslice_pkg::NUM_LANES); lane++) begin : gen_lane_en
    assign lane_en_o[lane] = is_fp16 & ((lane == 0) | vector);
  end

  // --------------------------------------------------------------------------
  // NaN-box check
  // --------------------------------------------------------------------------
  // A scalar FP16 operand must carry all ones above it, else it reads as qNaN
  always_comb begin : box_check
    lane_a_o = req_i.a;
    lane_b_o = req_i.b;
    if (scalar_fp16 && (req_i.a.h16[1] != '1)) begin
      lane_a_o.h16[0] = fpslice_pkg::FP16_QNAN;
    end
    if (scalar_fp16 && (req_i.b.h16[1] != '1)) begin
      lane_b_o.h16[0] = fpslice_pkg::FP16_QNAN;
    end
  end

  // Metadata rides along with the item through the pipeline
  assign meta_o = '{
    fmt:    req_i.fmt,
    vector: vector,
    tag:    req_i.tag
  };

endmodule

//--- fpslice_execute.sv
/* Execution stage: one FP32 lane and one lane per FP16 half, results bundled
   with the item's metadata into the pipeline payload. */
module fpslice_execute (
  input  fpslice_pkg::fp_word_u    lane_a_i,
  input  fpslice_pkg::fp_word_u    lane_b_i,
  input  fpslice_pkg::lane_mask_t  lane_en_i,
  input  fpslice_pkg::fp_op_e      op_i,
  input  fpslice_pkg::slice_meta_t meta_i,
  output fpslice_pkg::exec_res_t   res_o
);

  logic                                                             fp32_en;
  logic [fpslice_pkg::WIDTH-1:0]                                    res32;
  fpslice_pkg::status_t                                             status32;
  logic [fpslice_pkg::NUM_LANES-1:0][fpslice_pkg::LANE_WIDTH-1:0]   res16;
  fpslice_pkg::status_t [fpslice_pkg::NUM_LANES-1:0]                status16;

  assign fp32_en = (meta_i.fmt == fpslice_pkg::FP32);

  fpslice_minmax_lane #(
    .ExpBits ( fpslice_pkg::FP32_EXP_BITS ),
    .ManBits ( fpslice_pkg::FP32_MAN_BITS )
  ) u_lane_fp32 (
    .en_i     ( fp32_en       ),
    .a_i      ( lane_a_i.f32  ),
    .b_i      ( lane_b_i.f32  ),
    .op_i     ( op_i          ),
    .res_o    ( res32         ),
    .status_o ( status32      )
  );

  // Each FP16 lane works on its own half of the word
  for (genvar lane = 0; lane < int'(fpslice_pkg::NUM_LANES); lane++) begin : gen_fp16_lanes
    fpslice_minmax_lane #(
      .ExpBits ( fpslice_pkg::FP16_EXP_BITS ),
      .ManBits ( fpslice_pkg::FP16_MAN_BITS )
    ) u_lane_fp16 (
      .en_i     ( lane_en_i[lane]     ),
      .a_i      ( lane_a_i.h16[lane]  ),
      .b_i      ( lane_b_i.h16[lane]  ),
      .op_i     ( op_i                ),
      .res_o    ( res16[lane]         ),
      .status_o ( status16[lane]      )
    );
  end

  assign res_o = '{
    res32:    res32,
    status32: status32,
    res16:    res16,
    status16: status16,
    meta:     meta_i
  };

endmodule

//--- fpslice_minmax_lane.sv
/* One lane of min/max and sign injection for a given exponent and mantissa size.
   Instantiated once for FP32 and once per FP16 lane. */
module fpslice_minmax_lane #(
  parameter int unsigned ExpBits = 8,
  parameter int unsigned ManBits = 23
) (
  input  logic                     en_i,
  input  logic [ExpBits+ManBits:0] a_i,
  input  logic [ExpBits+ManBits:0] b_i,
  input  fpslice_pkg::fp_op_e      op_i,
  output logic [ExpBits+ManBits:0] res_o,
  output fpslice_pkg::status_t     status_o
);

  localparam int unsigned FP_WIDTH = 1 + ExpBits + ManBits;
  localparam logic [FP_WIDTH-1:0] QNAN = FP_WIDTH'(fpslice_pkg::qnan(ExpBits, ManBits));

  typedef struct packed {
    logic snan;
    logic qnan;
    logic zero;
  } fp_class_t;

  function automatic fp_class_t classify(logic [FP_WIDTH-1:0] val);
    fp_class_t cls;
    logic      exp_ones;
    logic      man_zero;
    exp_ones = &val[FP_WIDTH-2 -: ExpBits];
    man_zero = ~|val[ManBits-1:0];
    // Quiet bit is the mantissa MSB
    cls.snan = exp_ones & ~man_zero & ~val[ManBits-1];
    cls.qnan = exp_ones & val[ManBits-1];
    cls.zero = ~|val[FP_WIDTH-2:0];
    return cls;
  endfunction

  fp_class_t             a_cls;
  fp_class_t             b_cls;
  logic                  a_sign;
  logic                  b_sign;
  logic [FP_WIDTH-2:0]   a_mag;
  logic [FP_WIDTH-2:0]   b_mag;
  logic                  a_nan;
  logic                  b_nan;
  logic                  a_lt_b;
  logic [FP_WIDTH-1:0]   minmax_res;

  assign a_cls  = classify(a_i);
  assign b_cls  = classify(b_i);
  assign a_sign = a_i[FP_WIDTH-1];
  assign b_sign = b_i[FP_WIDTH-1];
  assign a_mag  = a_i[FP_WIDTH-2:0];
  assign b_mag  = b_i[FP_WIDTH-2:0];
  assign a_nan  = a_cls.snan | a_cls.qnan;
  assign b_nan  = b_cls.snan | b_cls.qnan;

  // Signed-magnitude order, -0 sorts below +0
  always_comb begin : order
    if (a_cls.zero && b_cls.zero) begin
      a_lt_b = a_sign & ~b_sign;
    end else if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = (a_mag > b_mag);
    end else begin
      a_lt_b = (a_mag < b_mag);
    end
  end

  // minNum/maxNum: a lone NaN loses to the number
  always_comb begin : minmax_sel
    if (a_nan && b_nan) begin
      minmax_res = QNAN;
    end else if (a_nan) begin
      minmax_res = b_i;
    end else if (b_nan) begin
      minmax_res = a_i;
    end else if (op_i == fpslice_pkg::MIN) begin
      minmax_res = a_lt_b ? a_i : b_i;
    end else begin
      minmax_res = a_lt_b ? b_i : a_i;
    end
  end

  // --------------------------------------------------------------------------
  // Operation select
  // --------------------------------------------------------------------------
  always_comb begin : op_sel
    res_o    = '0;
    status_o = '0;
    if (en_i) begin
      case (op_i)
        fpslice_pkg::MIN,
        fpslice_pkg::MAX: begin
          res_o       = minmax_res;
          status_o.nv = a_cls.snan | b_cls.snan;
        end
        fpslice_pkg::SGNJ:  res_o = {b_sign, a_mag};
        fpslice_pkg::SGNJN: res_o = {~b_sign, a_mag};
        fpslice_pkg::SGNJX: res_o = {a_sign ^ b_sign, a_mag};
        default:            res_o = '0;
      endcase
    end
  end

endmodule

//--- fpslice_pipe.sv
/* Valid/ready register pipeline of NumPipeRegs stages with flush and busy.
   A stage advances when the next one is ready or holds a bubble. */
module fpslice_pipe #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  fpslice_pkg::exec_res_t data_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  logic                   flush_i,
  output fpslice_pkg::exec_res_t data_o,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic                   busy_o
);

  // Index i holds the item after i register stages
  fpslice_pkg::exec_res_t [0:NumPipeRegs] pipe_data;
  logic [0:NumPipeRegs]                   pipe_valid;
  logic [0:NumPipeRegs]                   pipe_ready;

  assign pipe_data[0]  = data_i;
  assign pipe_valid[0] = valid_i;

  // --------------------------------------------------------------------------
  // Register stages
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < int'(NumPipeRegs); i++) begin : gen_stages
    logic stage_en;

    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];

    // Flush drops every item in flight
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid[i+1] <= pipe_valid[i];
      end
    end

    // Payload only moves with a real item
    assign stage_en = pipe_ready[i] & pipe_valid[i];

    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        pipe_data[i+1] <= pipe_data[i];
      end
    end
  end

  // Downstream drives the last ready
  assign pipe_ready[NumPipeRegs] = ready_i;

  assign ready_o = pipe_ready[0];
  assign data_o  = pipe_data[NumPipeRegs];
  assign valid_o = pipe_valid[NumPipeRegs];

  // Busy covers the register stages only, the input is not in flight yet
  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o = busy_o | pipe_valid[i];
    end
  end

endmodule

//--- fpslice_pkg.sv
/* Shared types and constants of the floating-point vector slice.
   Every design and testbench file refers to these by scoped names. */
package fpslice_pkg;

  // --------------------------------------------------------------------------
  // Widths and formats
  // --------------------------------------------------------------------------
  localparam int unsigned WIDTH      = 32;
  localparam int unsigned TAG_WIDTH  = 4;
  localparam int unsigned NUM_LANES  = 2;
  localparam int unsigned LANE_WIDTH = WIDTH / NUM_LANES;

  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Canonical quiet NaN: positive, exponent all ones, only the quiet bit set
  function automatic logic [WIDTH-1:0] qnan(int unsigned exp_bits, int unsigned man_bits);
    logic [WIDTH-1:0] val;
    val = '0;
    for (int unsigned i = 0; i < exp_bits + 1; i++) begin
      val[man_bits - 1 + i] = 1'b1;
    end
    return val;
  endfunction

  localparam logic [WIDTH-1:0]      FP32_QNAN = qnan(FP32_EXP_BITS, FP32_MAN_BITS);
  localparam logic [LANE_WIDTH-1:0] FP16_QNAN = LANE_WIDTH'(qnan(FP16_EXP_BITS, FP16_MAN_BITS));

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } fp_op_e;

  // IEEE exception flags, only nv is raised by this slice
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // --------------------------------------------------------------------------
  // Data words and payloads
  // --------------------------------------------------------------------------
  // One datapath word, seen as a single FP32 or as two FP16 lanes
  typedef union packed {
    logic [WIDTH-1:0]                     f32;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] h16;
  } fp_word_u;

  typedef struct packed {
    fp_word_u             a;
    fp_word_u             b;
    fp_op_e               op;
    fp_fmt_e              fmt;
    logic                 vector;
    logic [TAG_WIDTH-1:0] tag;
  } slice_req_t;

  typedef logic [NUM_LANES-1:0] lane_mask_t;

  typedef struct packed {
    fp_fmt_e              fmt;
    logic                 vector;
    logic [TAG_WIDTH-1:0] tag;
  } slice_meta_t;

  // Pipeline payload, all lane results travel until the output picks them
  typedef struct packed {
    logic [WIDTH-1:0]                     res32;
    status_t                              status32;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] res16;
    status_t [NUM_LANES-1:0]              status16;
    slice_meta_t                          meta;
  } exec_res_t;

endpackage

//--- fpslice_properties.sv
/* Handshake and flush assertions for the slice, attached to the top level by bind. */
module fpslice_properties #(
  parameter int unsigned NumPipeRegs = 2
) (
  input logic                              clk_i,
  input logic                              arst_n_i,
  input logic                              in_valid_i,
  input logic                              in_ready_o,
  input logic                              flush_i,
  input logic                              out_valid_o,
  input logic                              out_ready_i,
  input logic [fpslice_pkg::WIDTH-1:0]     result_o,
  input logic [fpslice_pkg::TAG_WIDTH-1:0] tag_o,
  input logic                              busy_o
);

  logic [7:0] in_flight;

  // Items held in the register stages, counted from the two handshakes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= '0;
    end else if (flush_i) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 8'(in_valid_i && in_ready_o) - 8'(out_valid_o && out_ready_i);
    end
  end

  no_valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
    else $error("output valid while in reset");

  // A stalled item keeps its place and its value
  stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(tag_o))
    else $error("stalled output changed");

  flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_o)
    else $error("output valid right after flush");

  busy_tracks_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_o == (in_flight != 0))
    else $error("busy_o does not match the items in flight");

  flight_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_flight <= NumPipeRegs)
    else $error("more items in flight than pipeline stages");

endmodule

bind fpslice_top fpslice_properties #(
  .NumPipeRegs ( NumPipeRegs )
) u_properties (
  .clk_i       ( clk_i       ),
  .arst_n_i    ( arst_n_i    ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .flush_i     ( flush_i     ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .result_o    ( result_o    ),
  .tag_o       ( tag_o       ),
  .busy_o      ( busy_o      )
);

//--- fpslice_result.sv
/* Output side: picks the result word by format, NaN-boxes unused FP16 lanes
   and ORs the lane flags into one status. */
module fpslice_result (
  input  fpslice_pkg::exec_res_t             data_i,
  output logic [fpslice_pkg::WIDTH-1:0]      result_o,
  output fpslice_pkg::status_t               status_o,
  output logic [fpslice_pkg::TAG_WIDTH-1:0]  tag_o
);

  fpslice_pkg::fp_word_u fp16_word;

  // --------------------------------------------------------------------------
  // FP16 packing
  // --------------------------------------------------------------------------
  // Upper lanes of a scalar item are filled with ones
  always_comb begin : pack_fp16
    for (int unsigned lane = 0; lane < fpslice_pkg::NUM_LANES; lane++) begin
      if ((lane == 0) || data_i.meta.vector) begin
        fp16_word.h16[lane] = data_i.res16[lane];
      end else begin
        fp16_word.h16[lane] = '1;
      end
    end
  end

  assign result_o = (data_i.meta.fmt == fpslice_pkg::FP32) ? data_i.res32 : fp16_word.f32;

  // Idle lanes report zero flags, so a plain OR is enough
  always_comb begin : collapse_status
    status_o = data_i.status32;
    for (int unsigned lane = 0; lane < fpslice_pkg::NUM_LANES; lane++) begin
      status_o = status_o | data_i.status16[lane];
    end
  end

  assign tag_o = data_i.meta.tag;

endmodule

//--- fpslice_top.sv
/* Top level of the floating-point min/max and sign-injection vector slice.
   Connects decode, execute, the handshake pipeline and the output packing. */
module fpslice_top #(
  parameter int unsigned NumPipeRegs   = 2,
  parameter bit          EnableVectors = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  fpslice_pkg::slice_req_t           req_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic                              flush_i,
  output logic [fpslice_pkg::WIDTH-1:0]     result_o,
  output fpslice_pkg::status_t              status_o,
  output logic [fpslice_pkg::TAG_WIDTH-1:0] tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);

  fpslice_pkg::fp_word_u    lane_a;
  fpslice_pkg::fp_word_u    lane_b;
  fpslice_pkg::lane_mask_t  lane_en;
  fpslice_pkg::slice_meta_t meta;
  fpslice_pkg::exec_res_t   exec_res;
  fpslice_pkg::exec_res_t   pipe_res;

  fpslice_decode #(
    .EnableVectors ( EnableVectors )
  ) u_decode (
    .req_i     ( req_i   ),
    .lane_a_o  ( lane_a  ),
    .lane_b_o  ( lane_b  ),
    .lane_en_o ( lane_en ),
    .meta_o    ( meta    )
  );

  fpslice_execute u_execute (
    .lane_a_i  ( lane_a   ),
    .lane_b_i  ( lane_b   ),
    .lane_en_i ( lane_en  ),
    .op_i      ( req_i.op ),
    .meta_i    ( meta     ),
    .res_o     ( exec_res )
  );

  // Single shared handshake for all lanes
  fpslice_pipe #(
    .NumPipeRegs ( NumPipeRegs )
  ) u_pipe (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .data_i   ( exec_res    ),
    .valid_i  ( in_valid_i  ),
    .ready_o  ( in_ready_o  ),
    .flush_i  ( flush_i     ),
    .data_o   ( pipe_res    ),
    .valid_o  ( out_valid_o ),
    .ready_i  ( out_ready_i ),
    .busy_o   ( busy_o      )
  );

  fpslice_result u_result (
    .data_i   ( pipe_res ),
    .result_o ( result_o ),
    .status_o ( status_o ),
    .tag_o    ( tag_o    )
  );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_fpslice -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_fpslice)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -q "PASS: all tests" || exit 1
exit 0

//--- tb_fpslice.sv
/* Testbench top of the slice: stimulus table applied twice, first with a free
   output then with random stalls, followed by a flush of items in flight. */
module tb_fpslice;

  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned NumEntries  = 16;
  // Two table passes plus the two flushed items
  localparam int unsigned CycleLimit  = (2 * NumEntries + 2) * (NumPipeRegs + 8) + 50;

  typedef struct packed {
    logic [8*14-1:0]        name;
    fpslice_pkg::slice_req_t req;
    logic [31:0]            exp_result;
    logic                   exp_nv;
  } entry_t;

  logic                              clk;
  logic                              arst_n;
  fpslice_pkg::slice_req_t           req;
  logic                              in_valid;
  logic                              in_ready;
  logic                              flush;
  logic [31:0]                       result;
  fpslice_pkg::status_t              status;
  logic [fpslice_pkg::TAG_WIDTH-1:0] tag;
  logic                              out_valid;
  logic                              out_ready;
  logic                              busy;
  logic [8*14-1:0]                   exp_name;
  logic [31:0]                       exp_result;
  logic                              exp_nv;
  logic                              check_latency;
  logic [1:0]                        ready_mode;
  logic [31:0]                       lfsr_state;
  int                                done_count;
  int                                pass_count;
  int                                error_count;
  int                                cycles;
  entry_t                            stim_q[$];

  tb_fpslice_clkgen u_clkgen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  fpslice_top #(
    .NumPipeRegs   ( NumPipeRegs ),
    .EnableVectors ( 1'b1        )
  ) dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .req_i       ( req       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  tb_fpslice_checker #(
    .NumPipeRegs ( NumPipeRegs )
  ) u_checker (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .in_valid_i      ( in_valid      ),
    .in_ready_i      ( in_ready      ),
    .flush_i         ( flush         ),
    .exp_name_i      ( exp_name      ),
    .exp_result_i    ( exp_result    ),
    .exp_nv_i        ( exp_nv        ),
    .exp_tag_i       ( req.tag       ),
    .check_latency_i ( check_latency ),
    .out_valid_i     ( out_valid     ),
    .out_ready_i     ( out_ready     ),
    .result_i        ( result        ),
    .status_i        ( status        ),
    .tag_i           ( tag           ),
    .busy_i          ( busy          ),
    .done_count_o    ( done_count    ),
    .pass_count_o    ( pass_count    ),
    .error_count_o   ( error_count   )
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic add_entry(input logic [8*14-1:0] name, input fpslice_pkg::fp_fmt_e fmt,
                           input logic vec, input fpslice_pkg::fp_op_e op,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] exp_res, input logic nv);
    entry_t e;
    e.name           = name;
    e.req.a.f32      = a;
    e.req.b.f32      = b;
    e.req.op         = op;
    e.req.fmt        = fmt;
    e.req.vector     = vec;
    e.req.tag        = fpslice_pkg::TAG_WIDTH'(stim_q.size());
    e.exp_result     = exp_res;
    e.exp_nv         = nv;
    stim_q.push_back(e);
  endtask

  // Holds the item on the inputs until the DUT takes it
  task automatic send_entry(input int idx, input logic lat);
    logic accepted;
    @(negedge clk);
    req           = stim_q[idx].req;
    exp_name      = stim_q[idx].name;
    exp_result    = stim_q[idx].exp_result;
    exp_nv        = stim_q[idx].exp_nv;
    check_latency = lat;
    in_valid      = 1'b1;
    accepted      = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = in_ready;
    end
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge clk);
    end
  endtask

  // Output ready: 0 free, 1 random stalls, 2 held low
  always @(negedge clk) begin
    if (ready_mode == 2'd1) begin
      lfsr_state = lfsr_step(lfsr_state);
      out_ready  = lfsr_state[0];
    end else begin
      out_ready = (ready_mode == 2'd0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("ERROR: timeout after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    cycles        = 0;
    req           = '0;
    in_valid      = 1'b0;
    flush         = 1'b0;
    out_ready     = 1'b1;
    ready_mode    = 2'd0;
    lfsr_state    = 32'h4847_14b5;
    exp_name      = '0;
    exp_result    = '0;
    exp_nv        = 1'b0;
    check_latency = 1'b0;

    // FP32 values: 1.0 3f800000, 2.0 40000000, -3.0 c0400000
    add_entry("f32_min", fpslice_pkg::FP32, 0, fpslice_pkg::MIN,
              32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 0);
    add_entry("f32_max_neg", fpslice_pkg::FP32, 0, fpslice_pkg::MAX,
              32'hc040_0000, 32'h3f80_0000, 32'h3f80_0000, 0);
    add_entry("f32_min_zero", fpslice_pkg::FP32, 0, fpslice_pkg::MIN,
              32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 0);
    add_entry("f32_max_qnan", fpslice_pkg::FP32, 0, fpslice_pkg::MAX,
              32'h7fc0_0000, 32'hc040_0000, 32'hc040_0000, 0);
    add_entry("f32_min_snan", fpslice_pkg::FP32, 0, fpslice_pkg::MIN,
              32'h4000_0000, 32'h7f80_0001, 32'h4000_0000, 1);
    add_entry("f32_two_nan", fpslice_pkg::FP32, 0, fpslice_pkg::MAX,
              32'h7fc0_0001, 32'hffc0_0000, 32'h7fc0_0000, 0);
    add_entry("f32_sgnj", fpslice_pkg::FP32, 0, fpslice_pkg::SGNJ,
              32'h3f80_0000, 32'hc040_0000, 32'hbf80_0000, 0);
    add_entry("f32_sgnjn", fpslice_pkg::FP32, 0, fpslice_pkg::SGNJN,
              32'hc040_0000, 32'hc040_0000, 32'h4040_0000, 0);
    add_entry("f32_sgnjx", fpslice_pkg::FP32, 0, fpslice_pkg::SGNJX,
              32'hc040_0000, 32'hbf80_0000, 32'h4040_0000, 0);
    // FP16 values: 1.0 3c00, 2.0 4000, -2.0 c000, sNaN 7c01
    add_entry("h16_vec_min", fpslice_pkg::FP16, 1, fpslice_pkg::MIN,
              32'h4000_3c00, 32'hc000_7c01, 32'hc000_3c00, 1);
    // Upper lane alone raises nv here
    add_entry("h16_vec_max", fpslice_pkg::FP16, 1, fpslice_pkg::MAX,
              32'h0000_8000, 32'h7c01_0000, 32'h0000_0000, 1);
    add_entry("h16_sc_max", fpslice_pkg::FP16, 0, fpslice_pkg::MAX,
              32'hffff_3c00, 32'hffff_4000, 32'hffff_4000, 0);
    add_entry("h16_sc_box", fpslice_pkg::FP16, 0, fpslice_pkg::MIN,
              32'h0000_3c00, 32'hffff_c000, 32'hffff_c000, 0);
    add_entry("h16_sc_sgnjn", fpslice_pkg::FP16, 0, fpslice_pkg::SGNJN,
              32'hffff_3c00, 32'hffff_3c00, 32'hffff_bc00, 0);
    add_entry("h16_vec_sgnjx", fpslice_pkg::FP16, 1, fpslice_pkg::SGNJX,
              32'hc000_3c00, 32'hc000_bc00, 32'h4000_bc00, 0);
    add_entry("h16_vec_sgnj", fpslice_pkg::FP16, 1, fpslice_pkg::SGNJ,
              32'h7c01_4000, 32'h8000_0000, 32'hfc01_4000, 0);

    @(posedge arst_n);

    // --------------------------------------------------------------------------
    // Free output with exact latency, then random stalls
    // --------------------------------------------------------------------------
    for (int pass = 0; pass < 2; pass++) begin
      ready_mode = 2'(pass);
      for (int i = 0; i < int'(NumEntries); i++) begin
        send_entry(i, (pass == 0));
      end
      @(negedge clk);
      in_valid = 1'b0;
      wait_done((pass + 1) * int'(NumEntries));
    end

    // Flush two items held in the stages
    ready_mode = 2'd2;
    @(negedge clk);
    send_entry(0, 1'b0);
    send_entry(1, 1'b0);
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b1;
    @(negedge clk);
    flush      = 1'b0;
    ready_mode = 2'd0;
    repeat (NumPipeRegs + 4) @(negedge clk);

    $display("tests: %0d passed, %0d errors", pass_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tb_fpslice_checker.sv
/* Scoreboard of the slice testbench: queues accepted items and compares each
   output handshake against them in order, with reset and flush checks. */
module tb_fpslice_checker #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              in_valid_i,
  input  logic                              in_ready_i,
  input  logic                              flush_i,
  input  logic [8*14-1:0]                   exp_name_i,
  input  logic [31:0]                       exp_result_i,
  input  logic                              exp_nv_i,
  input  logic [fpslice_pkg::TAG_WIDTH-1:0] exp_tag_i,
  input  logic                              check_latency_i,
  input  logic                              out_valid_i,
  input  logic                              out_ready_i,
  input  logic [31:0]                       result_i,
  input  fpslice_pkg::status_t              status_i,
  input  logic [fpslice_pkg::TAG_WIDTH-1:0] tag_i,
  input  logic                              busy_i,
  output int                                done_count_o,
  output int                                pass_count_o,
  output int                                error_count_o
);

  typedef struct packed {
    logic [8*14-1:0]                   name;
    logic [31:0]                       result;
    fpslice_pkg::status_t              status;
    logic [fpslice_pkg::TAG_WIDTH-1:0] tag;
    logic                              check_latency;
    logic [31:0]                       accept_cycle;
  } expect_t;

  expect_t     expect_q[$];
  expect_t     incoming;
  expect_t     head;
  logic [31:0] cycle = '0;
  logic        flush_q = 1'b0;
  logic        reset_seen = 1'b0;
  logic        reset_bad = 1'b0;

  initial begin
    done_count_o  = 0;
    pass_count_o  = 0;
    error_count_o = 0;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (!arst_n_i) begin
      if (out_valid_i || busy_i || !in_ready_i) begin
        $display("ERROR: wrong handshake state during reset");
        error_count_o++;
        reset_bad <= 1'b1;
      end
    end else begin
      if (!reset_seen) begin
        if (!reset_bad) begin
          $display("ok   reset_state");
        end
        reset_seen <= 1'b1;
      end
      // Pipeline state one edge after a flush
      if (flush_q) begin
        if (busy_i || out_valid_i) begin
          $display("ERROR: busy_o or out_valid_o still high after flush");
          error_count_o++;
        end else begin
          $display("ok   flush_drop");
        end
      end
      if (in_valid_i && in_ready_i && !flush_i) begin
        incoming.name          = exp_name_i;
        incoming.result        = exp_result_i;
        incoming.status        = '0;
        incoming.status.nv     = exp_nv_i;
        incoming.tag           = exp_tag_i;
        incoming.check_latency = check_latency_i;
        incoming.accept_cycle  = cycle;
        expect_q.push_back(incoming);
      end
      if (out_valid_i && out_ready_i) begin
        if (expect_q.size() == 0) begin
          $display("ERROR: output with tag %h and no item outstanding", tag_i);
          error_count_o++;
        end else begin
          head = expect_q.pop_front();
          done_count_o++;
          if (result_i !== head.result || status_i !== head.status || tag_i !== head.tag) begin
            $display("MISMATCH %s: expected result %h status %b tag %h, actual %h %b %h",
                     head.name, head.result, head.status, head.tag,
                     result_i, status_i, tag_i);
            error_count_o++;
          end else if (head.check_latency && (cycle - head.accept_cycle != NumPipeRegs)) begin
            $display("ERROR %s: result came %0d cycles after acceptance instead of %0d",
                     head.name, cycle - head.accept_cycle, NumPipeRegs);
            error_count_o++;
          end else begin
            $display("ok   %s tag %h result %h", head.name, tag_i, result_i);
            pass_count_o++;
          end
        end
      end
      if (flush_i) begin
        expect_q.delete();
      end
      flush_q <= flush_i;
    end
  end

endmodule

//--- tb_fpslice_clkgen.sv
/* Testbench clock and reset source, 10 unit period with reset held for 8 cycles. */
module tb_fpslice_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- verilog.f
fpslice_pkg.sv
fpslice_decode.sv
fpslice_minmax_lane.sv
fpslice_execute.sv
fpslice_pipe.sv
fpslice_result.sv
fpslice_top.sv
fpslice_properties.sv
tb_fpslice_clkgen.sv
tb_fpslice_checker.sv
tb_fpslice.sv
